// File: test/ooo_core_trace.txt
// line 1: program word count, expected commit count
// then one instruction word per line, then one commit per line as rd and value
0D 0D
00500093  // addi x1, x0, 5
FFD00113  // addi x2, x0, -3
002081B3  // add  x3, x1, x2
40208233  // sub  x4, x1, x2
00421293  // slli x5, x4, 4
00112333  // slt  x6, x2, x1
001133B3  // sltu x7, x2, x1
0FF2C413  // xori x8, x5, 0xff
40115493  // srai x9, x2, 1
00115533  // srl  x10, x2, x1
00708013  // addi x0, x1, 7
008060B3  // or   x1, x0, x8
00F0F593  // andi x11, x1, 0xf
01 00000005
02 FFFFFFFD
03 00000002
04 00000008
05 00000080
06 00000001
07 00000000
08 0000007F
09 FFFFFFFE
0A 07FFFFFF
00 0000000C
01 0000007F
0B 0000000F

// File: ooo_core.f
+incdir+rtl
rtl/ooo_core_pkg.sv
rtl/int_alu.sv
rtl/reservation_station.sv
rtl/reorder_buffer.sv
rtl/reg_status_file.sv
rtl/fetch_issue.sv
rtl/ooo_core.sv
test/ooo_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the ooo_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f ooo_core.f --top-module ooo_core_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vooo_core_tb)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Done: no errors" <<< "$sim_output"; then
    exit 0
fi
echo "simulation did not report a clean run"
exit 1

// File: test/ooo_core_tb.sv
`timescale 1ns/1ps

module ooo_core_tb;

    localparam int          RESET_CYCLES   = 16;
    localparam int          REQ_TIMEOUT    = 20;
    localparam int          COMMIT_TIMEOUT = 3000;
    localparam int          QUIET_CYCLES   = 60;
    localparam logic [31:0] LCG_SEED       = 32'h9b19ed93;

    logic        clk               = 1'b0;
    logic        rst_n_i           = 1'b1;
    logic        instr_mem_resp_i  = 1'b0;
    logic [31:0] instr_mem_rdata_i = '0;
    logic        instr_read_o;
    logic [31:0] instr_mem_address_o;
    logic        commit_valid_o;
    logic [4:0]  commit_rd_o;
    logic [31:0] commit_data_o;

    // word 0 and 1 are the counts, then the program, then rd/value pairs
    logic [31:0] trace_mem [0:127];
    int          n_prog      = 0;
    int          n_commit    = 0;
    int          commit_idx  = 0;
    int          errors      = 0;
    int          checks      = 0;
    int          req_count   = 0;
    int          mem_delay   = 0;
    bit          mem_pending = 1'b0;
    logic [31:0] lcg_state   = LCG_SEED;
    bit          timed_out   = 1'b0;

    always #50 clk = ~clk;

    ooo_core u_ooo_core (
        .clk                 (clk),
        .rst_n_i             (rst_n_i),
        .instr_mem_resp_i    (instr_mem_resp_i),
        .instr_mem_rdata_i   (instr_mem_rdata_i),
        .instr_read_o        (instr_read_o),
        .instr_mem_address_o (instr_mem_address_o),
        .commit_valid_o      (commit_valid_o),
        .commit_rd_o         (commit_rd_o),
        .commit_data_o       (commit_data_o)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s, got %h, expected %h",
                     $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic load_trace();
        $readmemh("test/ooo_core_trace.txt", trace_mem);
        n_prog   = int'(trace_mem[0]);
        n_commit = int'(trace_mem[1]);
        if (n_prog < 1 || n_commit < 1 || 2 + n_prog + 2 * n_commit > 128) begin
            $display("trace file is missing or its counts do not fit the trace array");
            errors++;
            n_prog   = 0;
            n_commit = 0;
        end
    endtask

    task automatic run_reset();
        rst_n_i <= 1'b0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            check_value(32'(instr_read_o), 32'd0, "instr_read_o high during reset");
            check_value(32'(commit_valid_o), 32'd0, "commit_valid_o high during reset");
        end
        rst_n_i <= 1'b1;
        @(posedge clk);
        check_value(32'(instr_read_o), 32'd0, "instr_read_o high in release cycle");
        check_value(32'(commit_valid_o), 32'd0, "commit_valid_o high in release cycle");
    endtask

    task automatic wait_first_request(output bit expired);
        int cycles;
        expired = 1'b0;
        cycles  = 0;
        while (!instr_read_o && !expired) begin
            @(posedge clk);
            cycles++;
            if (cycles > REQ_TIMEOUT) begin
                $display("timeout: no instruction fetch request after reset");
                errors++;
                expired = 1'b1;
            end
        end
        if (!expired) begin
            check_value(instr_mem_address_o, 32'd0, "first fetch address");
        end
    endtask

    task automatic wait_for_commits(output bit expired);
        int cycles;
        expired = 1'b0;
        cycles  = 0;
        while (commit_idx < n_commit && !expired) begin
            @(posedge clk);
            cycles++;
            if (cycles > COMMIT_TIMEOUT) begin
                $display("timeout: only %0d of %0d expected commits seen in %0d cycles",
                         commit_idx, n_commit, COMMIT_TIMEOUT);
                errors++;
                expired = 1'b1;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // instruction memory with 0 to 3 extra cycles of latency
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!rst_n_i) begin
            instr_mem_resp_i <= 1'b0;
            mem_pending = 1'b0;
        end else begin
            instr_mem_resp_i <= 1'b0;
            if (instr_mem_resp_i) begin
                // this was the data cycle, read drops next
                mem_pending = 1'b0;
            end else if (instr_read_o) begin
                if (!mem_pending) begin
                    mem_pending = 1'b1;
                    check_value(instr_mem_address_o, 32'(req_count * 4),
                                $sformatf("fetch address of request %0d", req_count));
                    req_count++;
                    lcg_state = lcg_next(lcg_state);
                    mem_delay = int'(lcg_state[31:30]);
                end else begin
                    check_value(instr_mem_address_o, 32'((req_count - 1) * 4),
                                $sformatf("fetch address held for request %0d",
                                          req_count - 1));
                end
                if (mem_delay > 0) begin
                    mem_delay--;
                end else if (int'(instr_mem_address_o[31:2]) < n_prog) begin
                    instr_mem_resp_i  <= 1'b1;
                    instr_mem_rdata_i <= trace_mem[2 + int'(instr_mem_address_o[31:2])];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // commit monitor
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst_n_i && commit_valid_o) begin
            if (commit_idx < n_commit) begin
                check_value(32'(commit_rd_o), trace_mem[2 + n_prog + 2 * commit_idx],
                            $sformatf("rd of commit %0d", commit_idx));
                check_value(commit_data_o, trace_mem[3 + n_prog + 2 * commit_idx],
                            $sformatf("value of commit %0d", commit_idx));
            end else begin
                $display("unexpected commit to x%0d at %0t after the last expected one",
                         commit_rd_o, $time);
                errors++;
            end
            commit_idx <= commit_idx + 1;
        end
    end

    initial begin
        load_trace();
        run_reset();
        wait_first_request(timed_out);
        if (!timed_out) begin
            wait_for_commits(timed_out);
        end
        // nothing more may retire once the trace is used up
        if (!timed_out) begin
            repeat (QUIET_CYCLES) @(posedge clk);
        end
        $display("%0d checks, %0d errors, %0d commits", checks, errors, commit_idx);
        if (errors == 0 && !timed_out) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: rtl/ooo_core.sv
`timescale 1ns/1ps
`include "ooo_core_macros.svh"

module ooo_core (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   instr_mem_resp_i,
    input  ooo_core_pkg::word_t    instr_mem_rdata_i,
    output logic                   instr_read_o,
    output ooo_core_pkg::word_t    instr_mem_address_o,
    output logic                   commit_valid_o,
    output ooo_core_pkg::reg_idx_t commit_rd_o,
    output ooo_core_pkg::word_t    commit_data_o
);

    logic                                     rob_full;
    logic [`OOO_NUM_RS-1:0]                   rs_empty;
    logic                                     rob_load;
    logic [`OOO_NUM_RS-1:0]                   rs_load;
    logic                                     alloc;
    ooo_core_pkg::reg_idx_t                   rd;
    ooo_core_pkg::reg_idx_t                   rs1;
    ooo_core_pkg::reg_idx_t                   rs2;
    logic                                     use_imm;
    ooo_core_pkg::word_t                      imm;
    ooo_core_pkg::alu_op_t                    alu_op;
    ooo_core_pkg::rob_tag_t                   issue_tag;
    ooo_core_pkg::word_t                      rs1_data;
    logic                                     rs1_ready;
    ooo_core_pkg::rob_tag_t                   rs1_tag;
    ooo_core_pkg::word_t                      rs2_data;
    logic                                     rs2_ready;
    ooo_core_pkg::rob_tag_t                   rs2_tag;
    ooo_core_pkg::word_t                      src2_data;
    logic                                     src2_ready;
    logic [`OOO_ROB_DEPTH-1:0]                rob_done;
    ooo_core_pkg::word_t [`OOO_ROB_DEPTH-1:0] rob_result;
    ooo_core_pkg::rob_tag_t                   commit_tag;
    logic [`OOO_NUM_RS-1:0]                   exec_valid;
    ooo_core_pkg::rob_tag_t [`OOO_NUM_RS-1:0] exec_tag;
    ooo_core_pkg::word_t [`OOO_NUM_RS-1:0]    exec_data;

    fetch_issue u_fetch_issue (
        .clk                 (clk),
        .rst_n_i             (rst_n_i),
        .instr_mem_resp_i    (instr_mem_resp_i),
        .instr_mem_rdata_i   (instr_mem_rdata_i),
        .rob_full_i          (rob_full),
        .rs_empty_i          (rs_empty),
        .instr_read_o        (instr_read_o),
        .instr_mem_address_o (instr_mem_address_o),
        .rob_load_o          (rob_load),
        .rs_load_o           (rs_load),
        .alloc_o             (alloc),
        .rd_o                (rd),
        .rs1_o               (rs1),
        .rs2_o               (rs2),
        .use_imm_o           (use_imm),
        .imm_o               (imm),
        .alu_op_o            (alu_op)
    );

    reg_status_file u_reg_status_file (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .alloc_i       (alloc),
        .alloc_rd_i    (rd),
        .alloc_tag_i   (issue_tag),
        .rs1_i         (rs1),
        .rs2_i         (rs2),
        .commit_i      (commit_valid_o),
        .commit_rd_i   (commit_rd_o),
        .commit_tag_i  (commit_tag),
        .commit_data_i (commit_data_o),
        .rs1_data_o    (rs1_data),
        .rs1_ready_o   (rs1_ready),
        .rs1_tag_o     (rs1_tag),
        .rs2_data_o    (rs2_data),
        .rs2_ready_o   (rs2_ready),
        .rs2_tag_o     (rs2_tag)
    );

    // immediate forms never wait on the second operand
    assign src2_data  = use_imm ? imm : rs2_data;
    assign src2_ready = use_imm | rs2_ready;

    reorder_buffer u_reorder_buffer (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .rob_load_i     (rob_load),
        .rd_i           (rd),
        .exec_valid_i   (exec_valid),
        .exec_tag_i     (exec_tag),
        .exec_data_i    (exec_data),
        .issue_tag_o    (issue_tag),
        .rob_full_o     (rob_full),
        .done_o         (rob_done),
        .result_o       (rob_result),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_tag_o   (commit_tag),
        .commit_data_o  (commit_data_o)
    );

    //////////////////////////////////////////////////////////////////////
    // stations and their ALUs
    //////////////////////////////////////////////////////////////////////

    for (genvar g = 0; g < `OOO_NUM_RS; g++) begin : g_rs
        ooo_core_pkg::alu_op_t op;
        ooo_core_pkg::word_t   opa;
        ooo_core_pkg::word_t   opb;

        reservation_station u_rs (
            .clk          (clk),
            .rst_n_i      (rst_n_i),
            .load_i       (rs_load[g]),
            .alu_op_i     (alu_op),
            .src1_data_i  (rs1_data),
            .src1_ready_i (rs1_ready),
            .src1_tag_i   (rs1_tag),
            .src2_data_i  (src2_data),
            .src2_ready_i (src2_ready),
            .src2_tag_i   (rs2_tag),
            .dest_tag_i   (issue_tag),
            .rob_done_i   (rob_done),
            .rob_result_i (rob_result),
            .empty_o      (rs_empty[g]),
            .exec_o       (exec_valid[g]),
            .op_o         (op),
            .opa_o        (opa),
            .opb_o        (opb),
            .tag_o        (exec_tag[g])
        );

        int_alu u_alu (
            .op_i (op),
            .a_i  (opa),
            .b_i  (opb),
            .y_o  (exec_data[g])
        );
    end

endmodule

// File: rtl/fetch_issue.sv
`timescale 1ns/1ps
`include "ooo_core_macros.svh"

module fetch_issue (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          instr_mem_resp_i,
    input  ooo_core_pkg::word_t           instr_mem_rdata_i,
    input  logic                          rob_full_i,
    input  logic [`OOO_NUM_RS-1:0]        rs_empty_i,
    output logic                          instr_read_o,
    output ooo_core_pkg::word_t           instr_mem_address_o,
    output logic                          rob_load_o,
    output logic [`OOO_NUM_RS-1:0]        rs_load_o,
    output logic                          alloc_o,
    output ooo_core_pkg::reg_idx_t        rd_o,
    output ooo_core_pkg::reg_idx_t        rs1_o,
    output ooo_core_pkg::reg_idx_t        rs2_o,
    output logic                          use_imm_o,
    output ooo_core_pkg::word_t           imm_o,
    output ooo_core_pkg::alu_op_t         alu_op_o
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    ooo_core_pkg::fetch_state_t state_q;
    ooo_core_pkg::fetch_state_t state_d;
    ooo_core_pkg::word_t        pc_q;
    ooo_core_pkg::word_t        ir_q;
    logic [6:0]                 opcode;
    logic [2:0]                 funct3;
    logic                       alt_f7;
    logic                       issue;
    logic [`OOO_NUM_RS-1:0]     pick;

    //////////////////////////////////////////////////////////////////////
    // fetch
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            ooo_core_pkg::FETCH_REQ:  state_d = ooo_core_pkg::FETCH_WAIT;
            ooo_core_pkg::FETCH_WAIT: if (instr_mem_resp_i) state_d = ooo_core_pkg::FETCH_HOLD;
            // next request goes out right after the issue edge
            ooo_core_pkg::FETCH_HOLD: if (issue) state_d = ooo_core_pkg::FETCH_WAIT;
            default:                  state_d = ooo_core_pkg::FETCH_REQ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ooo_core_pkg::FETCH_REQ;
            pc_q    <= '0;
        end else begin
            state_q <= state_d;
            if (issue) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ooo_core_pkg::FETCH_WAIT && instr_mem_resp_i) begin
            ir_q <= instr_mem_rdata_i;
        end
    end

    assign instr_read_o        = (state_q == ooo_core_pkg::FETCH_WAIT);
    assign instr_mem_address_o = pc_q;

    //////////////////////////////////////////////////////////////////////
    // decode and issue
    //////////////////////////////////////////////////////////////////////

    assign opcode    = ir_q[6:0];
    assign funct3    = ir_q[14:12];
    assign alt_f7    = ir_q[30];
    assign rd_o      = ir_q[11:7];
    assign rs1_o     = ir_q[19:15];
    assign rs2_o     = ir_q[24:20];
    assign use_imm_o = (opcode == OPC_OP_IMM);
    assign imm_o     = {{20{ir_q[31]}}, ir_q[31:20]};

    always_comb begin
        case (funct3)
            3'b000:  alu_op_o = (opcode == OPC_OP && alt_f7) ? ooo_core_pkg::ALU_SUB
                                                               : ooo_core_pkg::ALU_ADD;
            3'b001:  alu_op_o = ooo_core_pkg::ALU_SLL;
            3'b010:  alu_op_o = ooo_core_pkg::ALU_SLT;
            3'b011:  alu_op_o = ooo_core_pkg::ALU_SLTU;
            3'b100:  alu_op_o = ooo_core_pkg::ALU_XOR;
            // srai keeps bit 30 in its immediate too
            3'b101:  alu_op_o = alt_f7 ? ooo_core_pkg::ALU_SRA : ooo_core_pkg::ALU_SRL;
            3'b110:  alu_op_o = ooo_core_pkg::ALU_OR;
            default: alu_op_o = ooo_core_pkg::ALU_AND;
        endcase
    end

    // lowest empty station wins
    assign pick = rs_empty_i & (~rs_empty_i + 1'b1);

    assign issue      = (state_q == ooo_core_pkg::FETCH_HOLD) && !rob_full_i && (|rs_empty_i);
    assign rob_load_o = issue;
    assign alloc_o    = issue;
    assign rs_load_o  = issue ? pick : '0;

    // memory answers only an outstanding request
    a_resp_when_read: assert property (@(posedge clk) disable iff (!rst_n_i)
        instr_mem_resp_i |-> instr_read_o);

endmodule

// File: rtl/reg_status_file.sv
`timescale 1ns/1ps

module reg_status_file (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    alloc_i,
    input  ooo_core_pkg::reg_idx_t  alloc_rd_i,
    input  ooo_core_pkg::rob_tag_t  alloc_tag_i,
    input  ooo_core_pkg::reg_idx_t  rs1_i,
    input  ooo_core_pkg::reg_idx_t  rs2_i,
    input  logic                    commit_i,
    input  ooo_core_pkg::reg_idx_t  commit_rd_i,
    input  ooo_core_pkg::rob_tag_t  commit_tag_i,
    input  ooo_core_pkg::word_t     commit_data_i,
    output ooo_core_pkg::word_t     rs1_data_o,
    output logic                    rs1_ready_o,
    output ooo_core_pkg::rob_tag_t  rs1_tag_o,
    output ooo_core_pkg::word_t     rs2_data_o,
    output logic                    rs2_ready_o,
    output ooo_core_pkg::rob_tag_t  rs2_tag_o
);

    ooo_core_pkg::word_t    regs_q [32];
    ooo_core_pkg::rob_tag_t tags_q [32];
    logic [31:0]            busy_q;
    logic                   hit1;
    logic                   hit2;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= '0;
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            if (commit_i && commit_rd_i != '0) begin
                regs_q[commit_rd_i] <= commit_data_i;
                // a younger writer keeps the register busy
                if (tags_q[commit_rd_i] == commit_tag_i) begin
                    busy_q[commit_rd_i] <= 1'b0;
                end
            end
            // allocation comes last so it wins over the clear
            if (alloc_i && alloc_rd_i != '0) begin
                busy_q[alloc_rd_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_i && alloc_rd_i != '0) begin
            tags_q[alloc_rd_i] <= alloc_tag_i;
        end
    end

    // value committing this cycle is forwarded to the reader
    assign hit1 = commit_i && busy_q[rs1_i] && (tags_q[rs1_i] == commit_tag_i);
    assign hit2 = commit_i && busy_q[rs2_i] && (tags_q[rs2_i] == commit_tag_i);

    assign rs1_ready_o = (rs1_i == '0) || !busy_q[rs1_i] || hit1;
    assign rs2_ready_o = (rs2_i == '0) || !busy_q[rs2_i] || hit2;
    assign rs1_data_o  = hit1 ? commit_data_i : regs_q[rs1_i];
    assign rs2_data_o  = hit2 ? commit_data_i : regs_q[rs2_i];
    assign rs1_tag_o   = tags_q[rs1_i];
    assign rs2_tag_o   = tags_q[rs2_i];

endmodule

// File: rtl/reorder_buffer.sv
`timescale 1ns/1ps
`include "ooo_core_macros.svh"

module reorder_buffer (
    input  logic                                            clk,
    input  logic                                            rst_n_i,
    input  logic                                            rob_load_i,
    input  ooo_core_pkg::reg_idx_t                          rd_i,
    input  logic [`OOO_NUM_RS-1:0]                          exec_valid_i,
    input  ooo_core_pkg::rob_tag_t [`OOO_NUM_RS-1:0]        exec_tag_i,
    input  ooo_core_pkg::word_t [`OOO_NUM_RS-1:0]           exec_data_i,
    output ooo_core_pkg::rob_tag_t                          issue_tag_o,
    output logic                                            rob_full_o,
    output logic [`OOO_ROB_DEPTH-1:0]                       done_o,
    output ooo_core_pkg::word_t [`OOO_ROB_DEPTH-1:0]        result_o,
    output logic                                            commit_valid_o,
    output ooo_core_pkg::reg_idx_t                          commit_rd_o,
    output ooo_core_pkg::rob_tag_t                          commit_tag_o,
    output ooo_core_pkg::word_t                             commit_data_o
);

    localparam int CNT_W = $clog2(`OOO_ROB_DEPTH) + 1;

    ooo_core_pkg::rob_tag_t                   head_q;
    ooo_core_pkg::rob_tag_t                   tail_q;
    logic [CNT_W-1:0]                         count_q;
    logic [`OOO_ROB_DEPTH-1:0]                busy_q;
    logic [`OOO_ROB_DEPTH-1:0]                done_q;
    ooo_core_pkg::reg_idx_t                   rd_q [`OOO_ROB_DEPTH];
    ooo_core_pkg::word_t [`OOO_ROB_DEPTH-1:0] result_q;

    //////////////////////////////////////////////////////////////////////
    // pointers and entry status
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            busy_q  <= '0;
            done_q  <= '0;
        end else begin
            // stations always finish on distinct tags
            for (int i = 0; i < `OOO_NUM_RS; i++) begin
                if (exec_valid_i[i]) begin
                    done_q[exec_tag_i[i]] <= 1'b1;
                end
            end
            if (rob_load_i) begin
                busy_q[tail_q] <= 1'b1;
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            if (commit_valid_o) begin
                busy_q[head_q] <= 1'b0;
                done_q[head_q] <= 1'b0;
                head_q         <= head_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(rob_load_i) - CNT_W'(commit_valid_o);
        end
    end

    always_ff @(posedge clk) begin
        if (rob_load_i) begin
            rd_q[tail_q] <= rd_i;
        end
        for (int i = 0; i < `OOO_NUM_RS; i++) begin
            if (exec_valid_i[i]) begin
                result_q[exec_tag_i[i]] <= exec_data_i[i];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////////////////////////

    assign issue_tag_o    = tail_q;
    assign rob_full_o     = (count_q == CNT_W'(`OOO_ROB_DEPTH));
    assign done_o         = done_q;
    assign result_o       = result_q;
    assign commit_valid_o = busy_q[head_q] && done_q[head_q];
    assign commit_rd_o    = rd_q[head_q];
    assign commit_tag_o   = head_q;
    assign commit_data_o  = result_q[head_q];

    a_no_load_full: assert property (@(posedge clk) disable iff (!rst_n_i)
        rob_load_i |-> !rob_full_o);

    for (genvar g = 0; g < `OOO_NUM_RS; g++) begin : g_chk
        a_exec_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
            exec_valid_i[g] |-> busy_q[exec_tag_i[g]] && !done_q[exec_tag_i[g]]);
    end

endmodule

// File: rtl/reservation_station.sv
`timescale 1ns/1ps
`include "ooo_core_macros.svh"

module reservation_station (
    input  logic                                        clk,
    input  logic                                        rst_n_i,
    input  logic                                        load_i,
    input  ooo_core_pkg::alu_op_t                       alu_op_i,
    input  ooo_core_pkg::word_t                         src1_data_i,
    input  logic                                        src1_ready_i,
    input  ooo_core_pkg::rob_tag_t                      src1_tag_i,
    input  ooo_core_pkg::word_t                         src2_data_i,
    input  logic                                        src2_ready_i,
    input  ooo_core_pkg::rob_tag_t                      src2_tag_i,
    input  ooo_core_pkg::rob_tag_t                      dest_tag_i,
    input  logic [`OOO_ROB_DEPTH-1:0]                   rob_done_i,
    input  ooo_core_pkg::word_t [`OOO_ROB_DEPTH-1:0]    rob_result_i,
    output logic                                        empty_o,
    output logic                                        exec_o,
    output ooo_core_pkg::alu_op_t                       op_o,
    output ooo_core_pkg::word_t                         opa_o,
    output ooo_core_pkg::word_t                         opb_o,
    output ooo_core_pkg::rob_tag_t                      tag_o
);

    logic                   occupied_q;
    logic                   a_ready_q;
    logic                   b_ready_q;
    ooo_core_pkg::alu_op_t  op_q;
    ooo_core_pkg::word_t    a_data_q;
    ooo_core_pkg::word_t    b_data_q;
    ooo_core_pkg::rob_tag_t a_tag_q;
    ooo_core_pkg::rob_tag_t b_tag_q;
    ooo_core_pkg::rob_tag_t dest_q;
    logic                   snoop_a;
    logic                   snoop_b;

    // a waiting operand is picked up once its producer is done in the ROB
    assign snoop_a = occupied_q && !a_ready_q && rob_done_i[a_tag_q];
    assign snoop_b = occupied_q && !b_ready_q && rob_done_i[b_tag_q];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            occupied_q <= 1'b0;
            a_ready_q  <= 1'b0;
            b_ready_q  <= 1'b0;
        end else if (load_i) begin
            occupied_q <= 1'b1;
            a_ready_q  <= src1_ready_i;
            b_ready_q  <= src2_ready_i;
        end else begin
            if (exec_o) begin
                occupied_q <= 1'b0;
            end
            if (snoop_a) begin
                a_ready_q <= 1'b1;
            end
            if (snoop_b) begin
                b_ready_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            op_q     <= alu_op_i;
            a_data_q <= src1_data_i;
            b_data_q <= src2_data_i;
            a_tag_q  <= src1_tag_i;
            b_tag_q  <= src2_tag_i;
            dest_q   <= dest_tag_i;
        end else begin
            if (snoop_a) begin
                a_data_q <= rob_result_i[a_tag_q];
            end
            if (snoop_b) begin
                b_data_q <= rob_result_i[b_tag_q];
            end
        end
    end

    // fires for exactly one cycle, empty again from the next
    assign exec_o  = occupied_q && a_ready_q && b_ready_q;
    assign empty_o = !occupied_q;
    assign op_o    = op_q;
    assign opa_o   = a_data_q;
    assign opb_o   = b_data_q;
    assign tag_o   = dest_q;

    a_no_load_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
        load_i |-> !occupied_q);

endmodule

// File: rtl/int_alu.sv
`timescale 1ns/1ps

module int_alu (
    input  ooo_core_pkg::alu_op_t op_i,
    input  ooo_core_pkg::word_t   a_i,
    input  ooo_core_pkg::word_t   b_i,
    output ooo_core_pkg::word_t   y_o
);

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ooo_core_pkg::ALU_ADD:  y_o = a_i + b_i;
            ooo_core_pkg::ALU_SUB:  y_o = a_i - b_i;
            ooo_core_pkg::ALU_SLL:  y_o = a_i << shamt;
            ooo_core_pkg::ALU_SLT:  y_o = ooo_core_pkg::word_t'($signed(a_i) < $signed(b_i));
            ooo_core_pkg::ALU_SLTU: y_o = ooo_core_pkg::word_t'(a_i < b_i);
            ooo_core_pkg::ALU_XOR:  y_o = a_i ^ b_i;
            ooo_core_pkg::ALU_SRL:  y_o = a_i >> shamt;
            ooo_core_pkg::ALU_SRA:  y_o = $signed(a_i) >>> shamt;
            ooo_core_pkg::ALU_OR:   y_o = a_i | b_i;
            ooo_core_pkg::ALU_AND:  y_o = a_i & b_i;
            default:                y_o = '0;
        endcase
    end

endmodule

// File: rtl/ooo_core_pkg.sv
`include "ooo_core_macros.svh"

package ooo_core_pkg;

    typedef logic [`OOO_XLEN-1:0] word_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] rob_tag_t;
    typedef logic [3:0] alu_op_t;

    // integer ALU operations
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLL  = 4'd2;
    localparam alu_op_t ALU_SLT  = 4'd3;
    localparam alu_op_t ALU_SLTU = 4'd4;
    localparam alu_op_t ALU_XOR  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_OR   = 4'd8;
    localparam alu_op_t ALU_AND  = 4'd9;

    typedef enum logic [1:0] {
        FETCH_REQ,
        FETCH_WAIT,
        FETCH_HOLD
    } fetch_state_t;

endpackage

// File: rtl/ooo_core_macros.svh
`ifndef OOO_CORE_MACROS_SVH
`define OOO_CORE_MACROS_SVH

// datapath width
`define OOO_XLEN 32

// reorder buffer entries, kept a power of two so the pointers wrap
`define OOO_ROB_DEPTH 8

// one ALU behind each station
`define OOO_NUM_RS 2

`endif
